// File: project.f
+incdir+common
common/arithPkg.sv
delayLine/delayLine.sv
source/cmdDecode.sv
source/arithExecute.sv
source/resultQueue.sv
source/arithTop.sv
verification/arithTb_assert.sv
verification/arithTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= arithTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/arithTb.sv
module arithTb;

    timeunit 1ns;
    timeprecision 100ps;

    import arithPkg::*;

    localparam int ROWS       = 14;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        tagField tag;
        opField  op;
        dataWord a;
        dataWord b;
        wideWord value;
        logic    err;
    } tableRow;

    logic        clk;
    logic        rst;
    logic        cmdReq;
    cmdPacket    cmd;
    logic        cmdAck;
    logic        resReq;
    resultPacket res;
    logic        resAck;

    tableRow     rows [ROWS];
    logic [31:0] rngState;
    int          checks;
    int          mismatches;
    int          timeouts;

    arithTop DUT (
        .clk   (clk),
        .rst   (rst),
        .cmdReq(cmdReq),
        .cmd   (cmd),
        .cmdAck(cmdAck),
        .resReq(resReq),
        .res   (res),
        .resAck(resAck)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic setRow(input int idx, input tagField tag, input opField op,
                          input dataWord a, input dataWord b,
                          input wideWord value, input logic err);
        rows[idx] = '{tag, op, a, b, value, err};
    endtask

    // Expected values worked out by hand, operands zero-extended to 32 bits
    task automatic fillTable();
        setRow(0,  4'h0, OP_ADD, 16'h0003, 16'h0004, 32'h0000_0007, 1'b0);
        setRow(1,  4'h1, OP_ADD, 16'hFFFF, 16'hFFFF, 32'h0001_FFFE, 1'b0);
        setRow(2,  4'h2, OP_SUB, 16'h1000, 16'h0001, 32'h0000_0FFF, 1'b0);
        setRow(3,  4'h3, OP_SUB, 16'h0000, 16'h0001, 32'hFFFF_FFFF, 1'b0);
        setRow(4,  4'h4, OP_SUB, 16'h0005, 16'hFFFF, 32'hFFFF_0006, 1'b0);
        setRow(5,  4'h5, OP_MUL, 16'h0012, 16'h0034, 32'h0000_03A8, 1'b0);
        setRow(6,  4'h6, OP_MUL, 16'hFFFF, 16'hFFFF, 32'hFFFE_0001, 1'b0);
        setRow(7,  4'h7, OP_MUL, 16'hFFFF, 16'h0000, 32'h0000_0000, 1'b0);
        setRow(8,  4'h8, OP_AND, 16'hF0F0, 16'h3C3C, 32'h0000_3030, 1'b0);
        setRow(9,  4'h9, OP_AND, 16'hFFFF, 16'hA5A5, 32'h0000_A5A5, 1'b0);
        setRow(10, 4'hA, 3'd4,   16'h1234, 16'h5678, 32'h0000_0000, 1'b1);
        setRow(11, 4'hB, 3'd7,   16'hFFFF, 16'hFFFF, 32'h0000_0000, 1'b1);
        setRow(12, 4'hC, OP_ADD, 16'h8000, 16'h8000, 32'h0001_0000, 1'b0);
        setRow(13, 4'hD, 3'd6,   16'hABCD, 16'h0002, 32'h0000_0000, 1'b1);
    endtask

    task automatic endRun();
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic waitCmdAck(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cmdAck !== level && cycles < WAIT_LIMIT);
        ok = (cmdAck === level);
        if (!ok) begin
            timeouts++;
            $display("Timeout: cmdAck did not go to %0b within %0d cycles",
                     level, WAIT_LIMIT);
        end
    endtask

    task automatic waitResReq(input logic level, output logic ok);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (resReq !== level && cycles < WAIT_LIMIT);
        ok = (resReq === level);
        if (!ok) begin
            timeouts++;
            $display("Timeout: resReq did not go to %0b within %0d cycles",
                     level, WAIT_LIMIT);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            mismatches++;
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic checkResult(input int idx);
        checkValue("res.tag", 32'(rows[idx].tag), 32'(res.tag));
        checkValue("res.value", rows[idx].value, res.value);
        checkValue("res.err", 32'(rows[idx].err), 32'(res.err));
    endtask

    // Both handshake outputs idle for a number of cycles
    task automatic expectQuiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            checkValue("resReq", 32'h0, 32'(resReq));
            checkValue("cmdAck", 32'h0, 32'(cmdAck));
        end
    endtask

    task automatic produce();
        logic ok;
        for (int i = 0; i < ROWS; i++) begin
            cmd.tag <= rows[i].tag;
            cmd.op  <= rows[i].op;
            cmd.a   <= rows[i].a;
            cmd.b   <= rows[i].b;
            cmdReq  <= 1'b1;
            waitCmdAck(1'b1, ok);
            cmdReq <= 1'b0;
            if (!ok) begin
                return;
            end
            waitCmdAck(1'b0, ok);
            if (!ok) begin
                return;
            end
        end
    endtask

    task automatic consume();
        int   pause;
        logic ok;
        for (int i = 0; i < ROWS; i++) begin
            waitResReq(1'b1, ok);
            if (!ok) begin
                return;
            end
            rngState = nextRandom(rngState);
            pause = int'(rngState[2:0]);
            // Long stall so the queue fills and advance drops
            if ((i + 1) % 10 == 0) begin
                pause = pause + 20;
            end
            repeat (pause) @(posedge clk);
            checkResult(i);
            resAck <= 1'b1;
            waitResReq(1'b0, ok);
            resAck <= 1'b0;
            if (!ok) begin
                return;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cmdReq     = 1'b0;
        cmd        = '0;
        resAck     = 1'b0;
        rngState   = 32'h4417;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        fillTable();

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        expectQuiet(8);

        fork
            produce();
            consume();
        join

        // Nothing left over once every row came back
        if (timeouts == 0) begin
            expectQuiet(30);
        end
        endRun();
    end

endmodule

// File: verification/arithTb_assert.sv
module arithHandshakeChecks (
    input logic                  clk,
    input logic                  rst,
    input logic                  cmdReq,
    input logic                  cmdAck,
    input logic                  resReq,
    input arithPkg::resultPacket res,
    input logic                  resAck
);

    timeunit 1ns;
    timeprecision 100ps;

    // Offered result waits for the consumer
    resReqHeld: assert property (@(posedge clk) disable iff (rst)
        resReq && !resAck |=> resReq)
        else $error("resReq dropped before resAck was seen");

    resStable: assert property (@(posedge clk) disable iff (rst)
        resReq |=> !resReq || $stable(res))
        else $error("res changed while resReq was high");

    // Ack may only drop once the request is gone
    cmdAckHeld: assert property (@(posedge clk) disable iff (rst)
        cmdAck && cmdReq |=> cmdAck)
        else $error("cmdAck fell while cmdReq was still high");

    resetQuiet: assert property (@(posedge clk)
        rst |=> !resReq && !cmdAck)
        else $error("resReq or cmdAck active right after reset");

endmodule

bind arithTop arithHandshakeChecks handshakeChecks (
    .clk   (clk),
    .rst   (rst),
    .cmdReq(cmdReq),
    .cmdAck(cmdAck),
    .resReq(resReq),
    .res   (res),
    .resAck(resAck)
);

// File: source/arithTop.sv
`include "arith_cfg.svh"

module arithTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmdReq,
    input  arithPkg::cmdPacket    cmd,
    output logic                  cmdAck,
    output logic                  resReq,
    output arithPkg::resultPacket res,
    input  logic                  resAck
);

    import arithPkg::*;

    logic        advance;
    logic        decValid;
    decodedOp    dec;
    logic        exeValid;
    resultPacket exeRes;

    cmdDecode decodeStage (
        .clk     (clk),
        .rst     (rst),
        .cmdReq  (cmdReq),
        .cmd     (cmd),
        .cmdAck  (cmdAck),
        .advance (advance),
        .decValid(decValid),
        .dec     (dec)
    );

    arithExecute executeStage (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .decValid(decValid),
        .dec     (dec),
        .exeValid(exeValid),
        .exeRes  (exeRes)
    );

    // Queue room drives the shared advance enable
    resultQueue queueStage (
        .clk     (clk),
        .rst     (rst),
        .exeValid(exeValid),
        .exeRes  (exeRes),
        .advance (advance),
        .resReq  (resReq),
        .res     (res),
        .resAck  (resAck)
    );

endmodule

// File: source/resultQueue.sv
`include "arith_cfg.svh"

module resultQueue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  exeValid,
    input  arithPkg::resultPacket exeRes,
    output logic                  advance,
    output logic                  resReq,
    output arithPkg::resultPacket res,
    input  logic                  resAck
);

    import arithPkg::*;

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W+1)'(DEPTH);

    resultPacket      mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Stall everything upstream once every entry is taken
    assign advance = (count < FULL_COUNT);
    assign push    = exeValid && advance;
    assign pop     = resReq && resAck;

    // Head stays put until it is acknowledged
    assign res = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= exeRes;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Output side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            resReq <= 1'b0;
        end else if (pop) begin
            resReq <= 1'b0;
        end else if (!resReq && (count != '0) && !resAck) begin
            resReq <= 1'b1;
        end
    end

endmodule

// File: source/arithExecute.sv
`include "arith_cfg.svh"

module arithExecute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  decValid,
    input  arithPkg::decodedOp    dec,
    output logic                  exeValid,
    output arithPkg::resultPacket exeRes
);

    import arithPkg::*;

    wideWord     aWide;
    wideWord     bWide;
    resultPacket opRes;

    // Zero extension before every operation
    assign aWide = wideWord'(dec.a);
    assign bWide = wideWord'(dec.b);

    always_comb begin
        opRes.tag   = dec.tag;
        opRes.err   = dec.illegal;
        opRes.value = '0;
        if (!dec.illegal) begin
            case (dec.op)
                OP_ADD:  opRes.value = aWide + bWide;
                OP_SUB:  opRes.value = aWide - bWide;
                OP_MUL:  opRes.value = aWide * bWide;
                OP_AND:  opRes.value = aWide & bWide;
                default: opRes.value = '0;
            endcase
        end
    end

    // Retiming registers, free for the synthesizer to push logic into
    delayLine #(
        .WIDTH($bits(resultPacket)),
        .DEPTH(`EXEC_DEPTH)
    ) resultPipe (
        .clk (clk),
        .rst (rst),
        .en  (advance),
        .din (opRes),
        .dout(exeRes)
    );

    delayLine #(
        .WIDTH(1),
        .DEPTH(`EXEC_DEPTH)
    ) validPipe (
        .clk (clk),
        .rst (rst),
        .en  (advance),
        .din (decValid),
        .dout(exeValid)
    );

endmodule

// File: source/cmdDecode.sv
`include "arith_cfg.svh"

module cmdDecode (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmdReq,
    input  arithPkg::cmdPacket cmd,
    output logic               cmdAck,
    input  logic               advance,
    output logic               decValid,
    output arithPkg::decodedOp dec
);

    import arithPkg::*;

    decodeState state;
    logic       accept;

    // New command only when the pipeline can move
    assign accept = (state == IDLE) && cmdReq && advance;

    assign cmdAck = (state == ACKED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // Wait for the source to release its request
                    if (!cmdReq) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Valid holds while stalled so the item is not lost
    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (advance) begin
            decValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.tag     <= cmd.tag;
            dec.op      <= cmd.op;
            dec.a       <= cmd.a;
            dec.b       <= cmd.b;
            dec.illegal <= (cmd.op > OP_AND);
        end
    end

endmodule

// File: delayLine/delayLine.sv
module delayLine #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    generate
        if (DEPTH == 0) begin : gPass
            // No registers at all
            assign dout = din;
        end else begin : gRegs
            logic [WIDTH-1:0] stages [DEPTH];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stages[i] <= '0;
                    end
                end else if (en) begin
                    stages[0] <= din;
                    for (int i = 1; i < DEPTH; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            // Oldest entry leaves the line
            assign dout = stages[DEPTH-1];
        end
    endgenerate

endmodule

// File: common/arithPkg.sv
`include "arith_cfg.svh"

package arithPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWord;
    typedef logic [2*`DATA_WIDTH-1:0] wideWord;
    typedef logic [`TAG_WIDTH-1:0] tagField;
    typedef logic [2:0] opField;

    // Legal opcodes, anything above OP_AND is illegal
    localparam opField OP_ADD = 3'd0;
    localparam opField OP_SUB = 3'd1;
    localparam opField OP_MUL = 3'd2;
    localparam opField OP_AND = 3'd3;

    // Input port payload
    typedef struct packed {
        tagField tag;
        opField  op;
        dataWord a;
        dataWord b;
    } cmdPacket;

    typedef struct packed {
        tagField tag;
        opField  op;
        dataWord a;
        dataWord b;
        logic    illegal;
    } decodedOp;

    // Output port payload
    typedef struct packed {
        tagField tag;
        wideWord value;
        logic    err;
    } resultPacket;

    // Input handshake FSM
    typedef enum logic {
        IDLE,
        ACKED
    } decodeState;

endpackage

// File: common/arith_cfg.svh
`ifndef ARITH_CFG_SVH
`define ARITH_CFG_SVH

// Operand width in bits
`define DATA_WIDTH 16

// Tag carried with every command and returned unchanged with its result
`define TAG_WIDTH 4

// Retiming stages behind the execute logic
// Sets the fixed latency of the execute stage in advanced cycles
`define EXEC_DEPTH 3

// Result entries held before the pipeline stalls
`define QUEUE_DEPTH 4

`endif
